// ==== video_pkg.sv ====
package video_pkg;

	// ***********************************************************************
	// pixel and position widths
	// ***********************************************************************

	localparam int pixel_bit    = 8;
	localparam int pos_bit      = 11;
	localparam int ramp_cnt_bit = 7;
	localparam int step_bit     = 3;	// eight grey steps.

	typedef logic [pixel_bit-1:0]    pixel_t;
	typedef logic [pos_bit-1:0]      pos_t;
	typedef logic [ramp_cnt_bit-1:0] ramp_t;
	typedef logic [step_bit-1:0]     step_t;

	// ***********************************************************************
	// raster geometry
	// ***********************************************************************

	// horizontal segment lengths in pixels.
	localparam pos_t h_active = pos_t'(64);
	localparam pos_t h_front  = pos_t'(4);
	localparam pos_t h_sync   = pos_t'(8);
	localparam pos_t h_back   = pos_t'(8);

	localparam pos_t h_sync_start = h_active + h_front;
	localparam pos_t h_back_start = h_sync_start + h_sync;
	localparam pos_t h_total      = h_back_start + h_back;	// 84 pixels per line.

	// vertical segment lengths in lines.
	localparam pos_t v_active = pos_t'(16);
	localparam pos_t v_front  = pos_t'(2);
	localparam pos_t v_sync   = pos_t'(2);
	localparam pos_t v_back   = pos_t'(2);

	localparam pos_t v_sync_start = v_active + v_front;
	localparam pos_t v_sync_end   = v_sync_start + v_sync;
	localparam pos_t v_total      = v_sync_end + v_back;	// 22 lines per frame.

	// each band or bar covers one eighth of the active area.
	localparam pos_t h_band = pos_t'(h_active / 8);
	localparam pos_t v_band = pos_t'(v_active / 8);

	// ***********************************************************************
	// grey levels
	// ***********************************************************************

	localparam pixel_t full_scale = '1;
	localparam pixel_t grey_step  = pixel_t'(full_scale / 7);	// 36.

	// the top step is forced to full scale since 7 * 36 stops short of 255.
	function automatic pixel_t grey_level(input step_t step);
		if (step == '1)
			return full_scale;
		return grey_step * pixel_t'(step);
	endfunction

	// ***********************************************************************
	// enums
	// ***********************************************************************

	typedef enum logic [1:0]
	{
		pat_frame_ramp = 2'd0,
		pat_h_bands    = 2'd1,	// bands chosen by y.
		pat_v_bars     = 2'd2,	// bars chosen by x.
		pat_diag       = 2'd3
	} pattern_e;

	typedef enum logic [1:0]
	{
		ph_active,
		ph_front,
		ph_sync,
		ph_back
	} phase_e;

endpackage

// ==== video_timing.sv ====
module video_timing
(
	input  logic                         in_pclk,
	input  logic                         in_rstn,
	input  logic                         pix_en,

	output logic [video_pkg::pos_bit-1:0] t_x,
	output logic [video_pkg::pos_bit-1:0] t_y,
	output logic                         t_valid,
	output logic                         t_de,
	output logic                         t_hs,
	output logic                         t_vs
);

	video_pkg::pos_t   h_cnt;
	video_pkg::pos_t   v_cnt;
	video_pkg::pos_t   h_next;
	video_pkg::pos_t   v_next;
	video_pkg::phase_e phase;
	logic              line_end;
	logic              frame_end;
	logic              de;
	logic              hs;
	logic              vs;

	// the segment that a given horizontal count falls in.
	function automatic video_pkg::phase_e phase_of(input video_pkg::pos_t h);
		if (h < video_pkg::h_active)
			return video_pkg::ph_active;
		else if (h < video_pkg::h_sync_start)
			return video_pkg::ph_front;
		else if (h < video_pkg::h_back_start)
			return video_pkg::ph_sync;
		return video_pkg::ph_back;
	endfunction

	// ***********************************************************************
	// counters
	// ***********************************************************************

	assign line_end  = (h_cnt == video_pkg::h_total - video_pkg::pos_t'(1));
	assign frame_end = (v_cnt == video_pkg::v_total - video_pkg::pos_t'(1));

	assign h_next = line_end ? '0 : h_cnt + video_pkg::pos_t'(1);
	assign v_next = frame_end ? '0 : v_cnt + video_pkg::pos_t'(1);

	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
			phase <= video_pkg::ph_active;
		end
		else if (pix_en)
		begin
			h_cnt <= h_next;
			if (line_end)
				v_cnt <= v_next;

			// the phase moves on when the next count crosses into a new segment.
			unique case (phase)
				video_pkg::ph_active:
					if (h_next == video_pkg::h_active)
						phase <= video_pkg::ph_front;
				video_pkg::ph_front:
					if (h_next == video_pkg::h_sync_start)
						phase <= video_pkg::ph_sync;
				video_pkg::ph_sync:
					if (h_next == video_pkg::h_back_start)
						phase <= video_pkg::ph_back;
				video_pkg::ph_back:
					if (h_next == '0)
						phase <= video_pkg::ph_active;
			endcase
		end
	end

	// ***********************************************************************
	// derived flags and output registers
	// ***********************************************************************

	assign de = (phase == video_pkg::ph_active) && (v_cnt < video_pkg::v_active);
	assign hs = (phase == video_pkg::ph_sync);
	assign vs = (v_cnt >= video_pkg::v_sync_start) && (v_cnt < video_pkg::v_sync_end);

	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn)
		begin
			t_x     <= '0;
			t_y     <= '0;
			t_valid <= 1'b0;
			t_de    <= 1'b0;
			t_hs    <= 1'b0;
			t_vs    <= 1'b0;
		end
		else
		begin
			t_valid <= pix_en;
			if (pix_en)	// between enabled cycles the outputs hold.
			begin
				t_x  <= h_cnt;
				t_y  <= v_cnt;
				t_de <= de;
				t_hs <= hs;
				t_vs <= vs;
			end
		end
	end

	a_de_not_sync: assert property (@(posedge in_pclk) disable iff (!in_rstn)
		t_de |-> (!t_hs && !t_vs));

	a_phase_count: assert property (@(posedge in_pclk) disable iff (!in_rstn)
		phase == phase_of(h_cnt));

endmodule

// ==== pattern_gen.sv ====
module pattern_gen
(
	input  logic                           in_pclk,
	input  logic                           in_rstn,

	input  logic [video_pkg::pos_bit-1:0]   in_x,
	input  logic [video_pkg::pos_bit-1:0]   in_y,
	input  logic                           in_valid,
	input  logic                           in_de,
	input  logic                           in_hs,
	input  logic                           in_vs,
	input  video_pkg::pattern_e            in_pattern,

	output logic [video_pkg::pos_bit-1:0]   out_x,
	output logic [video_pkg::pos_bit-1:0]   out_y,
	output logic                           out_valid,
	output logic                           out_de,
	output logic                           out_hs,
	output logic                           out_vs,
	output logic [video_pkg::pixel_bit-1:0] out_data
);

	video_pkg::ramp_t  frame_cnt;
	video_pkg::pos_t   x_bar;
	video_pkg::pos_t   y_band;
	video_pkg::pos_t   diag_sum;
	video_pkg::pixel_t next_data;
	logic              vs_fall;

	// ***********************************************************************
	// timing pipeline
	// ***********************************************************************

	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn)
		begin
			out_x     <= '0;
			out_y     <= '0;
			out_valid <= 1'b0;
			out_de    <= 1'b0;
			out_hs    <= 1'b0;
			out_vs    <= 1'b0;
		end
		else
		begin
			out_x     <= in_x;
			out_y     <= in_y;
			out_valid <= in_valid;
			out_de    <= in_de;
			out_hs    <= in_hs;
			out_vs    <= in_vs;
		end
	end

	// ***********************************************************************
	// pixel value
	// ***********************************************************************

	// out_vs is the previous in_vs, so a drop between them ends a frame.
	assign vs_fall = out_vs && !in_vs;

	assign x_bar    = in_x / video_pkg::h_band;
	assign y_band   = in_y / video_pkg::v_band;
	assign diag_sum = in_x + in_y;

	always_comb
	begin
		next_data = out_data;	// outside the active area bands and bars keep their value.
		unique case (in_pattern)
			video_pkg::pat_frame_ramp:
				next_data = video_pkg::grey_level(
					frame_cnt[video_pkg::ramp_cnt_bit-1 -: video_pkg::step_bit]);
			video_pkg::pat_h_bands:
				if (in_y < video_pkg::v_active)
					next_data = video_pkg::grey_level(y_band[video_pkg::step_bit-1:0]);
			video_pkg::pat_v_bars:
				if (in_x < video_pkg::h_active)
					next_data = video_pkg::grey_level(x_bar[video_pkg::step_bit-1:0]);
			video_pkg::pat_diag:
				next_data = diag_sum[video_pkg::pixel_bit-1:0];	// wraps every 256.
		endcase
	end

	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn)
		begin
			frame_cnt <= '0;
			out_data  <= '0;
		end
		else
		begin
			out_data <= next_data;
			// the ramp moves one grey step every sixteen frames.
			if (vs_fall && in_pattern == video_pkg::pat_frame_ramp)
				frame_cnt <= frame_cnt + video_pkg::ramp_t'(1);
		end
	end

	a_de_in_active: assert property (@(posedge in_pclk) disable iff (!in_rstn)
		out_de |-> (out_x < video_pkg::h_active && out_y < video_pkg::v_active));

endmodule

// ==== video_top.sv ====
module video_top
(
	input  logic                           in_pclk,
	input  logic                           in_rstn,
	input  logic                           pix_en,
	input  video_pkg::pattern_e            pattern,

	output logic [video_pkg::pos_bit-1:0]   out_x,
	output logic [video_pkg::pos_bit-1:0]   out_y,
	output logic                           out_valid,
	output logic                           out_de,
	output logic                           out_hs,
	output logic                           out_vs,
	output logic [video_pkg::pixel_bit-1:0] out_data
);

	// raster position and flags run one clock behind the counters.
	logic [video_pkg::pos_bit-1:0] t_x;
	logic [video_pkg::pos_bit-1:0] t_y;
	logic                         t_valid;
	logic                         t_de;
	logic                         t_hs;
	logic                         t_vs;

	video_timing u_timing
	(
		.in_pclk (in_pclk),
		.in_rstn (in_rstn),
		.pix_en  (pix_en),
		.t_x     (t_x),
		.t_y     (t_y),
		.t_valid (t_valid),
		.t_de    (t_de),
		.t_hs    (t_hs),
		.t_vs    (t_vs)
	);

	pattern_gen u_pattern
	(
		.in_pclk    (in_pclk),
		.in_rstn    (in_rstn),
		.in_x       (t_x),
		.in_y       (t_y),
		.in_valid   (t_valid),
		.in_de      (t_de),
		.in_hs      (t_hs),
		.in_vs      (t_vs),
		.in_pattern (pattern),
		.out_x      (out_x),
		.out_y      (out_y),
		.out_valid  (out_valid),
		.out_de     (out_de),
		.out_hs     (out_hs),
		.out_vs     (out_vs),
		.out_data   (out_data)
	);

endmodule

// ==== tb_video_top.sv ====
module tb_video_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int frame_len       = int'(video_pkg::h_total) * int'(video_pkg::v_total);
	localparam int ramp_frames     = 129;	// one frame past the 7-bit counter wrap.
	localparam int test_frames     = 1 + 2 + 3 + ramp_frames + 4;
	localparam int watchdog_cycles = test_frames * frame_len * 2;

	typedef struct packed
	{
		video_pkg::pos_t   x;
		video_pkg::pos_t   y;
		logic              de;
		logic              hs;
		logic              vs;
		video_pkg::pixel_t data;
	} out_rec_t;

	logic                in_pclk;
	logic                in_rstn;
	logic                pix_en;
	video_pkg::pattern_e pattern;
	video_pkg::pos_t     out_x;
	video_pkg::pos_t     out_y;
	logic                out_valid;
	logic                out_de;
	logic                out_hs;
	logic                out_vs;
	video_pkg::pixel_t   out_data;

	out_rec_t    mon_q[$];	// one entry per valid output cycle.
	logic [31:0] rnd_state;

	video_top DUT
	(
		.in_pclk   (in_pclk),
		.in_rstn   (in_rstn),
		.pix_en    (pix_en),
		.pattern   (pattern),
		.out_x     (out_x),
		.out_y     (out_y),
		.out_valid (out_valid),
		.out_de    (out_de),
		.out_hs    (out_hs),
		.out_vs    (out_vs),
		.out_data  (out_data)
	);

	initial
	begin
		in_pclk = 1'b0;
		forever #5 in_pclk = ~in_pclk;
	end

	// ***********************************************************************
	// helpers
	// ***********************************************************************

	task automatic end_with_failure(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_pixel(input string name, input video_pkg::pixel_t exp,
		input video_pkg::pixel_t act);
		if (act !== exp)
			end_with_failure($sformatf("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act));
	endtask

	task automatic check_pos(input string name, input video_pkg::pos_t exp,
		input video_pkg::pos_t act);
		if (act !== exp)
			end_with_failure($sformatf("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			end_with_failure($sformatf("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// step 7 is full scale and the others are multiples of the grey step.
	function automatic video_pkg::pixel_t grey_of(input int step);
		if (step == 7)
			return 8'hff;
		return video_pkg::pixel_t'(step) * video_pkg::grey_step;
	endfunction

	function automatic video_pkg::pixel_t expected_pixel(input video_pkg::pattern_e pat,
		input video_pkg::pos_t x, input video_pkg::pos_t y, input int falls);
		case (pat)
			video_pkg::pat_frame_ramp:
				return grey_of((falls % 128) / 16);
			video_pkg::pat_h_bands:
				return grey_of(int'(y / video_pkg::v_band));
			video_pkg::pat_v_bars:
				return grey_of(int'(x / video_pkg::h_band));
			default:
				return video_pkg::pixel_t'(x + y);	// diagonal.
		endcase
	endfunction

	always @(negedge in_pclk)
	begin
		if (out_valid)
			mon_q.push_back(out_rec_t'{out_x, out_y, out_de, out_hs, out_vs, out_data});
	end

	task automatic next_record(output out_rec_t r);
		while (mon_q.size() == 0)
			@(posedge in_pclk);
		r = mon_q.pop_front();
	endtask

	task automatic check_idle();
		check_bit("out_valid", 1'b0, out_valid);
		check_bit("out_de", 1'b0, out_de);
		check_bit("out_hs", 1'b0, out_hs);
		check_bit("out_vs", 1'b0, out_vs);
		check_pos("out_x", '0, out_x);
		check_pos("out_y", '0, out_y);
		check_pixel("out_data", '0, out_data);
	endtask

	task automatic apply_reset(input logic en, input video_pkg::pattern_e pat);
		@(posedge in_pclk);
		#1;
		in_rstn = 1'b0;
		pix_en  = en;
		pattern = pat;
		repeat (4)
		begin
			@(posedge in_pclk);
			@(negedge in_pclk);
			check_idle();
		end
		@(posedge in_pclk);
		#1;
		in_rstn = 1'b1;
		mon_q.delete();
	endtask

	// ***********************************************************************
	// tests
	// ***********************************************************************

	task automatic test_reset();
		apply_reset(1'b1, video_pkg::pat_frame_ramp);
		@(negedge in_pclk);
		check_idle();
		@(negedge in_pclk);	// first clock after release.
		check_idle();
	endtask

	task automatic test_raster();
		out_rec_t r;
		int       de_run;
		int       hs_run;
		int       vs_run;
		int       de_lines;
		int       hs_lines;
		int       vs_pulses;
		de_run    = 0;
		hs_run    = 0;
		vs_run    = 0;
		de_lines  = 0;
		hs_lines  = 0;
		vs_pulses = 0;
		apply_reset(1'b1, video_pkg::pat_diag);
		for (int i = 0; i < 2 * frame_len; i++)
		begin
			next_record(r);
			if (i == 0)
			begin
				check_pos("out_x", '0, r.x);
				check_pos("out_y", '0, r.y);
			end
			if (r.de)
			begin
				check_bit("out_hs", 1'b0, r.hs);
				check_bit("out_vs", 1'b0, r.vs);
				check_pos("out_x", video_pkg::pos_t'(de_run), r.x);
				de_run++;
			end
			else if (de_run != 0)
			begin
				check_pos("de run length", video_pkg::h_active, video_pkg::pos_t'(de_run));
				de_lines++;
				de_run = 0;
			end
			if (r.hs)
				hs_run++;
			else if (hs_run != 0)
			begin
				check_pos("hs run length", video_pkg::h_sync, video_pkg::pos_t'(hs_run));
				hs_lines++;
				hs_run = 0;
			end
			if (r.vs)
				vs_run++;
			else if (vs_run != 0)
			begin
				check_pos("vs run length", video_pkg::v_sync * video_pkg::h_total,
					video_pkg::pos_t'(vs_run));
				check_pos("de lines per frame", video_pkg::v_active,
					video_pkg::pos_t'(de_lines));
				vs_pulses++;
				de_lines = 0;
				vs_run   = 0;
			end
		end
		check_pos("vs pulses", video_pkg::pos_t'(2), video_pkg::pos_t'(vs_pulses));
		check_pos("hs pulses", video_pkg::v_total * video_pkg::pos_t'(2),
			video_pkg::pos_t'(hs_lines));
	endtask

	task automatic test_spatial(input video_pkg::pattern_e pat);
		out_rec_t r;
		int       de_cnt;
		de_cnt = 0;
		apply_reset(1'b1, pat);
		for (int i = 0; i < frame_len; i++)
		begin
			next_record(r);
			if (r.de)
			begin
				check_pixel("out_data", expected_pixel(pat, r.x, r.y, 0), r.data);
				de_cnt++;
			end
		end
		check_pos("de cycles per frame", video_pkg::h_active * video_pkg::v_active,
			video_pkg::pos_t'(de_cnt));
	endtask

	task automatic test_frame_ramp();
		out_rec_t r;
		int       falls;
		logic     prev_vs;
		falls   = 0;
		prev_vs = 1'b0;
		apply_reset(1'b1, video_pkg::pat_frame_ramp);
		while (falls < ramp_frames)
		begin
			next_record(r);
			if (prev_vs && !r.vs)
				falls++;
			prev_vs = r.vs;
			if (r.de)
				check_pixel("out_data",
					expected_pixel(video_pkg::pat_frame_ramp, r.x, r.y, falls), r.data);
		end
	endtask

	task automatic test_pix_en();
		logic            en_hist[$];
		int              valid_cnt;
		video_pkg::pos_t ex;
		video_pkg::pos_t ey;
		video_pkg::pos_t px;
		video_pkg::pos_t py;
		logic            pde;
		logic            phs;
		logic            pvs;
		valid_cnt = 0;
		ex        = '0;
		ey        = '0;
		apply_reset(1'b0, video_pkg::pat_diag);
		en_hist.push_back(1'b0);	// the two cycles before the loop run with pix_en low.
		en_hist.push_back(1'b0);
		px  = out_x;
		py  = out_y;
		pde = out_de;
		phs = out_hs;
		pvs = out_vs;
		while (valid_cnt < frame_len)
		begin
			@(posedge in_pclk);
			#1;
			rnd_state = xorshift32(rnd_state);
			pix_en    = rnd_state[0];
			en_hist.push_back(pix_en);
			@(negedge in_pclk);
			check_bit("out_valid", en_hist[en_hist.size()-3], out_valid);
			if (out_valid)
			begin
				check_pos("out_x", ex, out_x);
				check_pos("out_y", ey, out_y);
				if (out_de)
					check_pixel("out_data",
						expected_pixel(video_pkg::pat_diag, out_x, out_y, 0), out_data);
				if (ex == video_pkg::h_total - video_pkg::pos_t'(1))
				begin
					ex = '0;
					ey = (ey == video_pkg::v_total - video_pkg::pos_t'(1)) ?
						'0 : ey + video_pkg::pos_t'(1);
				end
				else
					ex = ex + video_pkg::pos_t'(1);
				valid_cnt++;
			end
			else
			begin
				check_pos("out_x", px, out_x);
				check_pos("out_y", py, out_y);
				check_bit("out_de", pde, out_de);
				check_bit("out_hs", phs, out_hs);
				check_bit("out_vs", pvs, out_vs);
			end
			px  = out_x;
			py  = out_y;
			pde = out_de;
			phs = out_hs;
			pvs = out_vs;
		end
	endtask

	// ***********************************************************************
	// run
	// ***********************************************************************

	initial
	begin
		repeat (watchdog_cycles) @(posedge in_pclk);
		end_with_failure($sformatf("timeout: the tests did not finish in %0d clock cycles",
			watchdog_cycles));
	end

	initial
	begin
		in_rstn   = 1'b0;
		pix_en    = 1'b0;
		pattern   = video_pkg::pat_frame_ramp;
		rnd_state = 32'h2f7f;
		test_reset();
		test_raster();
		test_spatial(video_pkg::pat_h_bands);
		test_spatial(video_pkg::pat_v_bars);
		test_spatial(video_pkg::pat_diag);
		test_frame_ramp();
		test_pix_en();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== files.f ====
video_pkg.sv
video_timing.sv
pattern_gen.sv
video_top.sv
tb_video_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is non-zero when the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_video_top --Mdir "$OBJ" -o sim_tb -f files.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
